//--- design/qdense_defines.svh
// Widths and APB register offsets of the qdense engine, included by the package and the RTL
`ifndef QDENSE_DEFINES_SVH
`define QDENSE_DEFINES_SVH

// Activation, weight and int8 result width
`define QD_DATA_WIDTH 8

// Signed accumulator, wraps on overflow
`define QD_ACC_WIDTH 20

// Unsigned scale width, all of it fraction bits
`define QD_SCALE_BITS 16

// Right shift applied after the scale multiply
`define QD_SHIFT_BITS 5

// APB bus sizes
`define QD_APB_ADDR_WIDTH 5
`define QD_APB_DATA_WIDTH 32

// Register offsets
`define QD_REG_CTRL    5'h00
`define QD_REG_SCALE   5'h04
`define QD_REG_BIAS    5'h08
`define QD_REG_OPERAND 5'h0C
`define QD_REG_RESULT  5'h10

`endif

//--- design/qdensePkg.sv
// Shared structs and the APB write-word union, referenced by scoped name from the RTL
`include "qdense_defines.svh"

package qdensePkg;

    // OPERAND write word
    // Upper half is ignored
    typedef struct packed {
        logic [`QD_APB_DATA_WIDTH-2*`QD_DATA_WIDTH-1:0] reserved;
        logic signed [`QD_DATA_WIDTH-1:0]                weight;
        logic signed [`QD_DATA_WIDTH-1:0]                activation;
    } operandPair_t;

    // SCALE register word
    // Shift sits at 20:16, scale at 15:0
    typedef struct packed {
        logic [`QD_APB_DATA_WIDTH-`QD_SHIFT_BITS-`QD_SCALE_BITS-1:0] reserved;
        logic [`QD_SHIFT_BITS-1:0]                                   shift;
        logic [`QD_SCALE_BITS-1:0]                                   scale;
    } scaleCfg_t;

    // One APB write word, read as a pair or as a scale config by address
    typedef union packed {
        operandPair_t operand;
        scaleCfg_t    scaleCfg;
    } apbWord_t;

    // Accumulator command
    // Load and accumulate may come together
    typedef struct packed {
        logic                             load;
        logic                             accumulate;
        logic signed [`QD_DATA_WIDTH-1:0] activation;
        logic signed [`QD_DATA_WIDTH-1:0] weight;
    } macOp_t;

    // Finished accumulator value into the scaler
    typedef struct packed {
        logic                            valid;
        logic signed [`QD_ACC_WIDTH-1:0] value;
    } scaleReq_t;

    // Requantized int8 result out of the scaler
    typedef struct packed {
        logic                             valid;
        logic signed [`QD_DATA_WIDTH-1:0] result;
    } scaleRsp_t;

endpackage

//--- design/macAccumulator.sv
// Signed multiply-accumulate of activation and weight pairs onto a bias, for the engine's datapath
`timescale 1ns/100ps
`include "qdense_defines.svh"

module macAccumulator (
    input  logic                            clk,
    input  logic                            arstN,
    input  qdensePkg::macOp_t               macOp,
    input  logic signed [`QD_ACC_WIDTH-1:0] bias,
    output logic signed [`QD_ACC_WIDTH-1:0] acc
);

    localparam int DataW = `QD_DATA_WIDTH;
    localparam int AccW  = `QD_ACC_WIDTH;
    localparam int ProdW = 2 * DataW;

    logic signed [ProdW-1:0] product;
    logic signed [AccW-1:0]  productExt;
    logic signed [AccW-1:0]  base;
    logic signed [AccW-1:0]  accNext;

    // Full 16-bit signed product of the pair
    assign product = $signed(macOp.activation) * $signed(macOp.weight);

    // Widen to accumulator width
    assign productExt = {{(AccW-ProdW){product[ProdW-1]}}, product};

    // Load wins, so a pair arriving with it adds onto the bias
    assign base = macOp.load ? bias : acc;

    always_comb begin
        accNext = acc;
        if (macOp.accumulate) begin
            // Wraps at AccW bits
            accNext = base + productExt;
        end else if (macOp.load) begin
            accNext = bias;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            acc <= '0;
        end else begin
            acc <= accNext;
        end
    end

endmodule

//--- design/outputScaler.sv
// Two-stage requantizer turning a finished accumulator into an int8 result
`timescale 1ns/100ps
`include "qdense_defines.svh"

module outputScaler (
    input  logic                 clk,
    input  logic                 arstN,
    input  qdensePkg::scaleReq_t scaleReq,
    input  qdensePkg::scaleCfg_t scaleCfg,
    output qdensePkg::scaleRsp_t scaleRsp
);

    localparam int DataW   = `QD_DATA_WIDTH;
    localparam int AccW    = `QD_ACC_WIDTH;
    localparam int ScaleW  = `QD_SCALE_BITS;
    localparam int ShiftW  = `QD_SHIFT_BITS;
    localparam int ScaledW = AccW + ScaleW;

    // int8 limits, 0111...1 and 1000...0
    localparam logic [DataW-1:0] SatHigh = {1'b0, {(DataW-1){1'b1}}};
    localparam logic [DataW-1:0] SatLow  = {1'b1, {(DataW-1){1'b0}}};

    logic                 inSign;
    logic [AccW-1:0]      inMag;
    logic [ScaledW-1:0]   scaledFull;
    logic                 s1Valid;
    logic                 s1Sign;
    logic [AccW-1:0]      s1Mag;
    logic [ShiftW-1:0]    s1Shift;
    logic [AccW-1:0]      shiftedMag;
    logic [DataW-1:0]     satResult;
    logic                 rspValid;
    logic [DataW-1:0]     rspResult;

    // Stage 1
    // Unsigned magnitude times unsigned scale, sign kept aside
    assign inSign     = scaleReq.value[AccW-1];
    assign inMag      = inSign ? (~scaleReq.value + 1'b1) : scaleReq.value;
    assign scaledFull = inMag * scaleCfg.scale;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= scaleReq.valid;
        end
    end

    // Fraction bits dropped, shift travels with its request
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s1Sign  <= 1'b0;
            s1Mag   <= '0;
            s1Shift <= '0;
        end else if (scaleReq.valid) begin
            s1Sign  <= inSign;
            s1Mag   <= scaledFull[ScaledW-1:ScaleW];
            s1Shift <= scaleCfg.shift;
        end
    end

    // Stage 2
    // Shifting the magnitude truncates toward zero for both signs
    assign shiftedMag = s1Mag >> s1Shift;

    always_comb begin
        if (s1Sign) begin
            // Anything at or past 128 clips to -128
            satResult = (shiftedMag >= AccW'(SatLow)) ? SatLow : (~shiftedMag[DataW-1:0] + 1'b1);
        end else begin
            satResult = (shiftedMag > AccW'(SatHigh)) ? SatHigh : shiftedMag[DataW-1:0];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rspValid <= 1'b0;
        end else begin
            rspValid <= s1Valid;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rspResult <= '0;
        end else if (s1Valid) begin
            rspResult <= satResult;
        end
    end

    assign scaleRsp = '{valid: rspValid, result: rspResult};

endmodule

//--- design/qdenseCtrl.sv
// APB register block of the engine, issuing accumulate and finish commands and holding the result
`timescale 1ns/100ps
`include "qdense_defines.svh"

module qdenseCtrl (
    input  logic                                  clk,
    input  logic                                  arstN,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [`QD_APB_ADDR_WIDTH-1:0]         paddr,
    input  logic [`QD_APB_DATA_WIDTH-1:0]         pwdata,
    output logic [`QD_APB_DATA_WIDTH-1:0]         prdata,
    output logic                                  pready,
    output qdensePkg::macOp_t                     macOp,
    output logic signed [`QD_ACC_WIDTH-1:0]       bias,
    input  logic signed [`QD_ACC_WIDTH-1:0]       acc,
    output qdensePkg::scaleReq_t                  scaleReq,
    output qdensePkg::scaleCfg_t                  scaleCfg,
    input  qdensePkg::scaleRsp_t                  scaleRsp
);

    // CTRL write bits
    localparam int ClearBit  = 0;
    localparam int FinishBit = 1;

    qdensePkg::apbWord_t              wrWord;
    qdensePkg::scaleCfg_t             scaleCfgReg;
    logic                             access;
    logic                             writeDone;
    logic                             clearCmd;
    logic                             finishCmd;
    logic                             operandWrite;
    logic                             resultRead;
    logic [1:0]                       finishCount;
    logic                             pending;
    logic                             lastRsp;
    logic [`QD_DATA_WIDTH-1:0]        resultReg;
    logic                             resultValid;
    logic [`QD_DATA_WIDTH-1:0]        resultNow;
    logic                             validNow;

    // Access phase, writes never stall
    assign access    = psel & penable;
    assign writeDone = access & pwrite;

    // Same write word seen as a pair or as a scale config
    assign wrWord = pwdata;

    assign clearCmd     = writeDone & (paddr == `QD_REG_CTRL) & pwdata[ClearBit];
    assign finishCmd    = writeDone & (paddr == `QD_REG_CTRL) & pwdata[FinishBit];
    assign operandWrite = writeDone & (paddr == `QD_REG_OPERAND);
    assign resultRead   = access & ~pwrite & (paddr == `QD_REG_RESULT);

    // Finish also reloads the bias so the next vector can start at once
    assign macOp = '{load:       clearCmd | finishCmd,
                     accumulate: operandWrite,
                     activation: wrWord.operand.activation,
                     weight:     wrWord.operand.weight};

    // Scaler samples the accumulator on the finish edge
    assign scaleReq = '{valid: finishCmd, value: acc};
    assign scaleCfg = scaleCfgReg;

    // Finishes still in the scaler
    assign pending = (finishCount != 2'd0);
    assign lastRsp = scaleRsp.valid & (finishCount == 2'd1);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            finishCount <= 2'd0;
        end else begin
            case ({finishCmd, scaleRsp.valid})
                2'b10:   finishCount <= finishCount + 2'd1;
                2'b01:   finishCount <= finishCount - 2'd1;
                default: finishCount <= finishCount;
            endcase
        end
    end

    // Configuration registers
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            scaleCfgReg <= '0;
            bias        <= '0;
        end else begin
            if (writeDone && (paddr == `QD_REG_SCALE)) begin
                scaleCfgReg <= '{reserved: '0,
                                 shift:    wrWord.scaleCfg.shift,
                                 scale:    wrWord.scaleCfg.scale};
            end
            if (writeDone && (paddr == `QD_REG_BIAS)) begin
                bias <= pwdata[`QD_ACC_WIDTH-1:0];
            end
        end
    end

    // Result register, valid stays set once a result has arrived
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultReg   <= '0;
            resultValid <= 1'b0;
        end else if (scaleRsp.valid) begin
            resultReg   <= scaleRsp.result;
            resultValid <= 1'b1;
        end
    end

    // Arriving response bypasses into a stalled read
    assign resultNow = scaleRsp.valid ? scaleRsp.result : resultReg;
    assign validNow  = scaleRsp.valid | resultValid;

    // Hold a RESULT read until the last finish has come back
    assign pready = ~(resultRead & pending & ~lastRsp);

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                `QD_REG_CTRL:   prdata[0] = pending;
                `QD_REG_SCALE:  prdata = scaleCfgReg;
                // Bias reads back sign-extended
                `QD_REG_BIAS:   prdata = {{(`QD_APB_DATA_WIDTH-`QD_ACC_WIDTH){bias[`QD_ACC_WIDTH-1]}},
                                          bias};
                `QD_REG_RESULT: begin
                    prdata[`QD_DATA_WIDTH-1:0] = resultNow;
                    prdata[`QD_DATA_WIDTH]     = validNow;
                end
                default:        prdata = '0;
            endcase
        end
    end

endmodule

//--- design/qdenseTop.sv
// Top level of the qdense engine, an APB slave around the accumulator and output scaler
`timescale 1ns/100ps
`include "qdense_defines.svh"

module qdenseTop (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [`QD_APB_ADDR_WIDTH-1:0] paddr,
    input  logic [`QD_APB_DATA_WIDTH-1:0] pwdata,
    output logic [`QD_APB_DATA_WIDTH-1:0] prdata,
    output logic                          pready
);

    qdensePkg::macOp_t               macOp;
    logic signed [`QD_ACC_WIDTH-1:0] bias;
    logic signed [`QD_ACC_WIDTH-1:0] acc;
    qdensePkg::scaleReq_t            scaleReq;
    qdensePkg::scaleCfg_t            scaleCfg;
    qdensePkg::scaleRsp_t            scaleRsp;

    // Register block and command sequencing
    qdenseCtrl u_ctrl (
        .clk      (clk),
        .arstN    (arstN),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .macOp    (macOp),
        .bias     (bias),
        .acc      (acc),
        .scaleReq (scaleReq),
        .scaleCfg (scaleCfg),
        .scaleRsp (scaleRsp)
    );

    // Dot-product accumulator
    macAccumulator u_mac (
        .clk   (clk),
        .arstN (arstN),
        .macOp (macOp),
        .bias  (bias),
        .acc   (acc)
    );

    // Requantization to int8
    outputScaler u_scaler (
        .clk      (clk),
        .arstN    (arstN),
        .scaleReq (scaleReq),
        .scaleCfg (scaleCfg),
        .scaleRsp (scaleRsp)
    );

endmodule

//--- verif/qdenseTb.sv
// Self-checking testbench of the qdense engine, drives APB transfers and compares RESULT reads
`timescale 1ns/100ps
`include "qdense_defines.svh"

module qdenseTb;

    localparam int SeedValue = 26321;
    localparam int NumRandom = 50;
    // About 60 vectors of up to 18 transfers at 2 cycles each is 2200 cycles, doubled plus reset
    localparam int TimeoutCycles = 5000;

    logic                          clk;
    logic                          arstN;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [`QD_APB_ADDR_WIDTH-1:0] paddr;
    logic [`QD_APB_DATA_WIDTH-1:0] pwdata;
    logic [`QD_APB_DATA_WIDTH-1:0] prdata;
    logic                          pready;

    // Expected RESULT words, oldest first
    logic [31:0] expectQ[$];
    logic [31:0] resultSeen;
    logic [31:0] expectedResult;
    event        resultReadEv;
    int          checkCount;
    int          errorCount;
    int          cycleCount;
    int unsigned seedDummy;

    qdenseTop u_dut (
        .clk     (clk),
        .arstN   (arstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    always #50 clk = ~clk;

    // Expected int8 from the requantization rules
    function automatic logic [7:0] refRequant(input int biasVal, input logic [15:0] pairs[$],
                                              input logic [15:0] scale, input logic [4:0] shift);
        longint             sum;
        logic signed [19:0] accWrap;
        longint             mag;
        longint             scaled;
        sum = biasVal;
        foreach (pairs[i]) begin
            sum += longint'($signed(pairs[i][7:0])) * longint'($signed(pairs[i][15:8]));
        end
        // Accumulator wraps at 20 bits
        accWrap = sum[19:0];
        mag = (accWrap < 0) ? -longint'(accWrap) : longint'(accWrap);
        // Both steps on the magnitude, so rounding goes toward zero
        scaled = (mag * longint'(scale)) >> 16;
        scaled = scaled >> shift;
        if (accWrap < 0) begin
            return (scaled >= 128) ? 8'h80 : 8'(-scaled);
        end
        return (scaled > 127) ? 8'h7f : 8'(scaled);
    endfunction

    // Weight in the upper byte, activation in the lower
    function automatic logic [15:0] makePair(input int act, input int wt);
        return {wt[7:0], act[7:0]};
    endfunction

    // Starts 10 ns after a rising edge and returns at the same point after completion
    task automatic apbTransfer(input logic write, input logic [4:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #10;
        penable = 1'b1;
        // PREADY and PRDATA are settled at the falling edge
        @(negedge clk);
        // Only a RESULT read may wait
        if (write || addr != `QD_REG_RESULT) begin
            checkCount++;
            if (!pready) begin
                errorCount++;
                $display("[FAIL] pready expected 0x1 got 0x0 at address 0x%02h", addr);
            end
        end
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        if (!write && addr == `QD_REG_RESULT) begin
            resultSeen = prdata;
            -> resultReadEv;
        end
        @(posedge clk);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [4:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        apbTransfer(1'b1, addr, wdata, unused);
    endtask

    task automatic apbRead(input logic [4:0] addr, output logic [31:0] rdata);
        apbTransfer(1'b0, addr, '0, rdata);
    endtask

    task automatic checkReg(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("[FAIL] %s expected 0x%08h got 0x%08h", name, expected, got);
        end
    endtask

    // Every RESULT read takes the oldest expected word
    always @(resultReadEv) begin
        checkCount++;
        if (expectQ.size() == 0) begin
            errorCount++;
            $display("RESULT was read but no expected value was queued");
        end else begin
            expectedResult = expectQ.pop_front();
            if (resultSeen !== expectedResult) begin
                errorCount++;
                $display("[FAIL] prdata (RESULT) expected 0x%08h got 0x%08h",
                         expectedResult, resultSeen);
            end
        end
    end

    task automatic reportTest(input string name, input int errorsBefore);
        $display("Test %s finished with %0d errors", name, errorCount - errorsBefore);
    endtask

    // Config, clear, pairs and finish, then an optional RESULT read
    task automatic runVector(input int biasVal, input logic [15:0] pairs[$],
                             input logic [15:0] scale, input logic [4:0] shift, input bit readNow);
        logic [31:0] data;
        apbWrite(`QD_REG_SCALE, {11'd0, shift, scale});
        apbWrite(`QD_REG_BIAS, 32'(biasVal));
        apbWrite(`QD_REG_CTRL, 32'h1);
        foreach (pairs[i]) begin
            apbWrite(`QD_REG_OPERAND, {16'd0, pairs[i]});
        end
        apbWrite(`QD_REG_CTRL, 32'h2);
        if (readNow) begin
            expectQ.push_back({23'd0, 1'b1, refRequant(biasVal, pairs, scale, shift)});
            apbRead(`QD_REG_RESULT, data);
        end
    endtask

    task automatic testResetState();
        logic [31:0] data;
        int          errorsBefore;
        errorsBefore = errorCount;
        apbRead(`QD_REG_CTRL, data);
        checkReg("prdata (CTRL)", data, 32'h0);
        apbRead(`QD_REG_SCALE, data);
        checkReg("prdata (SCALE)", data, 32'h0);
        apbRead(`QD_REG_BIAS, data);
        checkReg("prdata (BIAS)", data, 32'h0);
        // No result yet, valid flag clear
        expectQ.push_back(32'h0);
        apbRead(`QD_REG_RESULT, data);
        reportTest("reset state", errorsBefore);
    endtask

    task automatic testReadback();
        logic [31:0] data;
        int          errorsBefore;
        errorsBefore = errorCount;
        // Junk above the shift field is dropped
        apbWrite(`QD_REG_SCALE, 32'hffea_1234);
        apbRead(`QD_REG_SCALE, data);
        checkReg("prdata (SCALE)", data, 32'h000a_1234);
        // -200 in 20 bits reads back sign-extended
        apbWrite(`QD_REG_BIAS, 32'h000f_ff38);
        apbRead(`QD_REG_BIAS, data);
        checkReg("prdata (BIAS)", data, 32'hffff_ff38);
        apbWrite(`QD_REG_BIAS, 32'h0001_2345);
        apbRead(`QD_REG_BIAS, data);
        checkReg("prdata (BIAS)", data, 32'h0001_2345);
        reportTest("register readback", errorsBefore);
    endtask

    task automatic testDirected();
        logic [15:0] pairs[$];
        int          errorsBefore;
        errorsBefore = errorCount;
        // 179 at half scale is 89.5, then 44.75 after the shift
        pairs.push_back(makePair(10, 20));
        pairs.push_back(makePair(-3, 7));
        runVector(0, pairs, 16'h8000, 5'd1, 1'b1);
        // -149 gives -37, flooring would give -38
        pairs.delete();
        pairs.push_back(makePair(-13, 11));
        runVector(-6, pairs, 16'h8000, 5'd1, 1'b1);
        pairs.delete();
        pairs.push_back(makePair(-9, -9));
        pairs.push_back(makePair(7, -3));
        runVector(37, pairs, 16'hc000, 5'd3, 1'b1);
        reportTest("directed dot products", errorsBefore);
    endtask

    task automatic testSaturation();
        logic [15:0] pairs[$];
        int          errorsBefore;
        errorsBefore = errorCount;
        pairs.push_back(makePair(100, 100));
        runVector(1000, pairs, 16'hffff, 5'd0, 1'b1);
        pairs.delete();
        pairs.push_back(makePair(-100, 100));
        runVector(-1000, pairs, 16'hffff, 5'd0, 1'b1);
        reportTest("saturation", errorsBefore);
    endtask

    task automatic testRandom();
        logic [15:0] pairs[$];
        int          count;
        int          biasVal;
        logic [15:0] scale;
        logic [4:0]  shift;
        int          errorsBefore;
        errorsBefore = errorCount;
        for (int v = 0; v < NumRandom; v++) begin
            // Bias and 16 pairs stay well inside 20 bits
            biasVal = int'($urandom % 262144) - 131072;
            count   = 1 + int'($urandom % 16);
            scale   = 16'($urandom);
            shift   = 5'($urandom % 12);
            pairs.delete();
            repeat (count) begin
                pairs.push_back(16'($urandom));
            end
            runVector(biasVal, pairs, scale, shift, 1'b1);
        end
        reportTest("random vectors", errorsBefore);
    endtask

    task automatic testBackToBack();
        logic [15:0] pairs[$];
        logic [31:0] data;
        int          errorsBefore;
        errorsBefore = errorCount;
        pairs.push_back(makePair(50, -40));
        runVector(3000, pairs, 16'h4000, 5'd3, 1'b0);
        // Second finish right behind, its vector is only the reloaded bias
        apbWrite(`QD_REG_CTRL, 32'h2);
        pairs.delete();
        expectQ.push_back({23'd0, 1'b1, refRequant(3000, pairs, 16'h4000, 5'd3)});
        apbRead(`QD_REG_RESULT, data);
        apbRead(`QD_REG_CTRL, data);
        checkReg("prdata (CTRL)", data, 32'h0);
        reportTest("back-to-back finishes", errorsBefore);
    endtask

    initial begin
        seedDummy  = $urandom(SeedValue);
        clk        = 1'b0;
        arstN      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        checkCount = 0;
        errorCount = 0;
        repeat (4) @(posedge clk);
        #10;
        arstN = 1'b1;
        @(posedge clk);
        #10;
        testResetState();
        testReadback();
        testDirected();
        testSaturation();
        testRandom();
        testBackToBack();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Stops a hung run
    initial begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- qdense.f
+incdir+design
design/qdensePkg.sv
design/macAccumulator.sv
design/outputScaler.sv
design/qdenseCtrl.sv
design/qdenseTop.sv
verif/qdenseTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the qdense testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE="$BUILD_DIR/sim.log"

if ! mkdir -p "$BUILD_DIR"; then
    echo "Could not create $BUILD_DIR"
    exit 1
fi

if ! verilator --binary --timing -Wno-fatal -f qdense.f --top-module qdenseTb \
        -Mdir "$BUILD_DIR/obj" -o simv; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./$BUILD_DIR/obj/simv" > "$LOG_FILE" 2>&1; then
    cat "$LOG_FILE"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$LOG_FILE"

if grep -q "Verification failed" "$LOG_FILE"; then
    exit 1
fi
exit 0
